/* rtl/net_stream_pkg.sv */
// Beat format of the network stream on both sides of the crossing.
// One beat is 64 data bits, a byte keep and a last flag.
// Widths are fixed here; the crossing logic derives its storage width from them.
package net_stream_pkg;

  // Data bits carried by one beat
  localparam int unsigned NET_DATA_BITS = 64;

  // One keep bit per data byte
  localparam int unsigned NET_KEEP_BITS = NET_DATA_BITS / 8;

  // Data word of one beat
  typedef logic [NET_DATA_BITS-1:0] net_data_t;

  // Byte enables of one beat, bit n covers data byte n
  typedef logic [NET_KEEP_BITS-1:0] net_keep_t;

endpackage

/* rtl/cdc_cfg_pkg.sv */
// Default sizing of the early clock crossing.
// The top level passes these down as module parameters.
// Synchronizer depths below 2 are not safe for metastability.
package cdc_cfg_pkg;

  // Register slices in each source and destination array
  localparam int unsigned DEF_N_STGS = 2;

  // FIFO address width, 4 gives 16 entries per direction
  localparam int unsigned DEF_FIFO_AW = 4;

  // Flops in each gray pointer chain and in the reset synchronizer
  localparam int unsigned DEF_SYNC_STGS = 2;

endpackage

/* rtl/net_stream_if.sv */
// Valid/ready stream of network beats.
// A beat moves on a rising edge with tvalid and tready both high.
// The source holds tvalid and payload steady until that edge.
`timescale 1ns/1ns

interface net_stream_if;
  import net_stream_pkg::*;

  // Payload of one beat
  net_data_t tdata;
  net_keep_t tkeep;
  logic      tlast;

  // Handshake
  logic      tvalid;
  logic      tready;

  // The producer side of a link
  modport src (
    output tdata,
    output tkeep,
    output tlast,
    output tvalid,
    input  tready
  );

  // The consumer side, mirror of src
  modport snk (
    input  tdata,
    input  tkeep,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

/* rtl/axis_reg_array.sv */
// Chain of N_STGS register slices on one clock, each with a skid buffer.
// Latency is N_STGS cycles when the output is not stalled, one beat per cycle.
// Every tready is registered; the array holds up to 2*N_STGS beats.
// Input tready is low during reset.
`timescale 1ns/1ns

module axis_reg_array #(
  parameter int unsigned N_STGS = 2
) (
  input logic        nclk,
  input logic        reset,
  net_stream_if.snk  s,
  net_stream_if.src  m
);
  import net_stream_pkg::*;

  // Data, keep and last packed into one register word
  localparam int unsigned BEAT_BITS = NET_DATA_BITS + NET_KEEP_BITS + 1;

  // Link n sits between slice n-1 and slice n and link 0 is the input
  logic [BEAT_BITS-1:0] pay [N_STGS+1];
  logic                 vld [N_STGS+1];
  logic                 rdy [N_STGS+1];

  assign pay[0]   = {s.tdata, s.tkeep, s.tlast};
  assign vld[0]   = s.tvalid;
  assign s.tready = rdy[0];

  assign {m.tdata, m.tkeep, m.tlast} = pay[N_STGS];
  assign m.tvalid    = vld[N_STGS];
  assign rdy[N_STGS] = m.tready;

  for (genvar i = 0; i < N_STGS; i++) begin : g_slice
    logic [BEAT_BITS-1:0] main_q;
    logic [BEAT_BITS-1:0] skid_q;
    logic                 main_vld;
    logic                 skid_vld;
    logic                 skid_vld_nxt;
    logic                 rdy_q;
    logic                 in_fire;
    logic                 out_free;

    // A beat is taken from upstream only while the skid slot is empty
    assign in_fire  = vld[i] && rdy_q;
    // The main register can be refilled when it is empty or being drained
    assign out_free = rdy[i+1] || !main_vld;

    // Skid slot fills when a beat arrives while the output is stalled
    always_comb begin
      skid_vld_nxt = skid_vld;
      if (out_free) begin
        skid_vld_nxt = 1'b0;
      end else if (in_fire) begin
        skid_vld_nxt = 1'b1;
      end
    end

    always_ff @(posedge nclk) begin
      if (reset) begin
        main_vld <= 1'b0;
        skid_vld <= 1'b0;
        rdy_q    <= 1'b0;
      end else begin
        skid_vld <= skid_vld_nxt;
        rdy_q    <= !skid_vld_nxt;
        if (out_free) begin
          main_vld <= skid_vld || in_fire;
        end
      end
    end

    // Main register takes the skid beat before a new upstream beat
    always_ff @(posedge nclk) begin
      if (out_free) begin
        if (skid_vld) begin
          main_q <= skid_q;
        end else if (in_fire) begin
          main_q <= pay[i];
        end
      end
      if (in_fire && !out_free) begin
        skid_q <= pay[i];
      end
    end

    assign rdy[i]   = rdy_q;
    assign vld[i+1] = main_vld;
    assign pay[i+1] = main_q;
  end

  // A stalled output beat must neither vanish nor change across the chain
  a_out_hold: assert property (
    @(posedge nclk) disable iff (reset)
    m.tvalid && !m.tready |=> m.tvalid && $stable({m.tdata, m.tkeep, m.tlast})
  );

endmodule

/* rtl/async_stream_fifo.sv */
// Dual clock FIFO for network beats with gray coded pointers.
// Holds 2**FIFO_AW beats, counting the one in the read output register.
// Full and empty are pessimistic because the far pointer arrives late.
// wr.tready is low while wr_reset is high; both resets must overlap in time.
`timescale 1ns/1ns

module async_stream_fifo #(
  parameter int unsigned FIFO_AW   = 4,
  parameter int unsigned SYNC_STGS = 2
) (
  input logic        wr_clk,
  input logic        wr_reset,
  input logic        rd_clk,
  input logic        rd_reset,
  net_stream_if.snk  wr,
  net_stream_if.src  rd
);
  import net_stream_pkg::*;

  localparam int unsigned BEAT_BITS = NET_DATA_BITS + NET_KEEP_BITS + 1;
  localparam int unsigned DEPTH     = 2 ** FIFO_AW;

  // Pointers carry one extra wrap bit to tell full from empty
  logic [BEAT_BITS-1:0] mem [DEPTH];

  logic [FIFO_AW:0]     wbin;
  logic [FIFO_AW:0]     wbin_nxt;
  logic [FIFO_AW:0]     wgray;
  logic [FIFO_AW:0]     wocc;
  logic [FIFO_AW:0]     wocc_nxt;
  logic [FIFO_AW:0]     rdone_sync [SYNC_STGS];
  logic [FIFO_AW:0]     rdone_bin_s;
  logic                 wr_rdy_q;
  logic                 wr_fire;

  logic [FIFO_AW:0]     rbin;
  logic [FIFO_AW:0]     rdone;
  logic [FIFO_AW:0]     rdone_nxt;
  logic [FIFO_AW:0]     rdone_gray;
  logic [FIFO_AW:0]     rocc;
  logic [FIFO_AW:0]     wgray_sync [SYNC_STGS];
  logic [FIFO_AW:0]     wbin_s;
  logic [BEAT_BITS-1:0] out_q;
  logic                 out_vld;
  logic                 load;
  logic                 rd_fire;

  function automatic logic [FIFO_AW:0] bin2gray(input logic [FIFO_AW:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] g);
    logic [FIFO_AW:0] b;
    b[FIFO_AW] = g[FIFO_AW];
    for (int i = int'(FIFO_AW) - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Write domain
  assign wr_fire     = wr.tvalid && wr_rdy_q;
  assign wbin_nxt    = wbin + {{FIFO_AW{1'b0}}, wr_fire};
  assign rdone_bin_s = gray2bin(rdone_sync[SYNC_STGS-1]);
  assign wocc        = wbin - rdone_bin_s;
  assign wocc_nxt    = wbin_nxt - rdone_bin_s;
  assign wr.tready   = wr_rdy_q;

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      wbin     <= '0;
      wgray    <= '0;
      wr_rdy_q <= 1'b0;
      for (int i = 0; i < SYNC_STGS; i++) begin
        rdone_sync[i] <= '0;
      end
    end else begin
      wbin  <= wbin_nxt;
      // Gray pointer leaves the domain straight from a flop
      wgray <= bin2gray(wbin_nxt);
      // Ready is registered, so full is judged one write ahead
      wr_rdy_q      <= wocc_nxt != DEPTH;
      rdone_sync[0] <= rdone_gray;
      for (int i = 1; i < SYNC_STGS; i++) begin
        rdone_sync[i] <= rdone_sync[i-1];
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wbin[FIFO_AW-1:0]] <= {wr.tdata, wr.tkeep, wr.tlast};
    end
  end

  // Read domain
  // rbin points at the next entry to load, rdone counts beats handed downstream
  assign wbin_s    = gray2bin(wgray_sync[SYNC_STGS-1]);
  assign load      = (wbin_s != rbin) && (!out_vld || rd.tready);
  assign rd_fire   = out_vld && rd.tready;
  assign rdone_nxt = rdone + {{FIFO_AW{1'b0}}, rd_fire};
  assign rocc      = wbin_s - rdone;

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      rbin       <= '0;
      rdone      <= '0;
      rdone_gray <= '0;
      out_vld    <= 1'b0;
      for (int i = 0; i < SYNC_STGS; i++) begin
        wgray_sync[i] <= '0;
      end
    end else begin
      rbin       <= rbin + {{FIFO_AW{1'b0}}, load};
      rdone      <= rdone_nxt;
      rdone_gray <= bin2gray(rdone_nxt);
      if (load) begin
        out_vld <= 1'b1;
      end else if (rd_fire) begin
        out_vld <= 1'b0;
      end
      wgray_sync[0] <= wgray;
      for (int i = 1; i < SYNC_STGS; i++) begin
        wgray_sync[i] <= wgray_sync[i-1];
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (load) begin
      out_q <= mem[rbin[FIFO_AW-1:0]];
    end
  end

  assign rd.tvalid = out_vld;
  assign {rd.tdata, rd.tkeep, rd.tlast} = out_q;

  // Write side never accepts into a slot the read side has not released
  a_no_write_full: assert property (
    @(posedge wr_clk) disable iff (wr_reset)
    wr_fire |-> wocc != DEPTH
  );

  // A beat leaves only when the synced write pointer shows it was written
  a_no_read_empty: assert property (
    @(posedge rd_clk) disable iff (rd_reset)
    rd_fire |-> (rocc != 0) && (rocc <= DEPTH)
  );

endmodule

/* rtl/net_ccross_early.sv */
// Early clock crossing between the raw line clock rclk and the stack clock nclk.
// Each direction runs a register array, an async FIFO and a second array.
// reset is synchronous to nclk; the rclk copy lags by SYNC_STGS rclk cycles,
// so reset must stay high long enough to cover that lag.
`timescale 1ns/1ns

module net_ccross_early #(
  parameter int unsigned N_STGS    = 2,
  parameter int unsigned FIFO_AW   = 4,
  parameter int unsigned SYNC_STGS = 2
) (
  input logic        rclk,
  input logic        nclk,
  input logic        reset,
  net_stream_if.snk  s_rclk,
  net_stream_if.snk  s_nclk,
  net_stream_if.src  m_rclk,
  net_stream_if.src  m_nclk
);

  logic                 n_reset_q;
  logic [SYNC_STGS-1:0] r_reset_sync;
  logic                 r_reset;

  // Register reset once in its own domain to ease fanout
  always_ff @(posedge nclk) begin
    n_reset_q <= reset;
  end

  // Bring the registered reset over into rclk
  always_ff @(posedge rclk) begin
    r_reset_sync <= {r_reset_sync[SYNC_STGS-2:0], n_reset_q};
  end

  assign r_reset = r_reset_sync[SYNC_STGS-1];

  // Links between arrays and FIFOs, named by direction and FIFO side
  net_stream_if r2n_wr ();
  net_stream_if r2n_rd ();
  net_stream_if n2r_wr ();
  net_stream_if n2r_rd ();

  // Line clock to stack clock
  axis_reg_array #(.N_STGS(N_STGS)) u_r2n_src_arr (
    .nclk  (rclk),
    .reset (r_reset),
    .s     (s_rclk),
    .m     (r2n_wr)
  );

  async_stream_fifo #(.FIFO_AW(FIFO_AW), .SYNC_STGS(SYNC_STGS)) u_r2n_fifo (
    .wr_clk   (rclk),
    .wr_reset (r_reset),
    .rd_clk   (nclk),
    .rd_reset (n_reset_q),
    .wr       (r2n_wr),
    .rd       (r2n_rd)
  );

  axis_reg_array #(.N_STGS(N_STGS)) u_r2n_dst_arr (
    .nclk  (nclk),
    .reset (n_reset_q),
    .s     (r2n_rd),
    .m     (m_nclk)
  );

  // Stack clock back to line clock
  axis_reg_array #(.N_STGS(N_STGS)) u_n2r_src_arr (
    .nclk  (nclk),
    .reset (n_reset_q),
    .s     (s_nclk),
    .m     (n2r_wr)
  );

  async_stream_fifo #(.FIFO_AW(FIFO_AW), .SYNC_STGS(SYNC_STGS)) u_n2r_fifo (
    .wr_clk   (nclk),
    .wr_reset (n_reset_q),
    .rd_clk   (rclk),
    .rd_reset (r_reset),
    .wr       (n2r_wr),
    .rd       (n2r_rd)
  );

  axis_reg_array #(.N_STGS(N_STGS)) u_n2r_dst_arr (
    .nclk  (rclk),
    .reset (r_reset),
    .s     (n2r_rd),
    .m     (m_rclk)
  );

endmodule

/* rtl/net_cdc_top.sv */
// Top level of the network clock crossing with plain stream ports.
// r_in and r_out are on rclk, n_in and n_out on nclk.
// reset is synchronous to nclk and active high.
`timescale 1ns/1ns

module net_cdc_top #(
  parameter int unsigned N_STGS    = cdc_cfg_pkg::DEF_N_STGS,
  parameter int unsigned FIFO_AW   = cdc_cfg_pkg::DEF_FIFO_AW,
  parameter int unsigned SYNC_STGS = cdc_cfg_pkg::DEF_SYNC_STGS
) (
  input  logic                      rclk,
  input  logic                      nclk,
  input  logic                      reset,
  // Line side input, rclk
  input  net_stream_pkg::net_data_t r_in_tdata,
  input  net_stream_pkg::net_keep_t r_in_tkeep,
  input  logic                      r_in_tlast,
  input  logic                      r_in_tvalid,
  output logic                      r_in_tready,
  // Stack side output, nclk
  output net_stream_pkg::net_data_t n_out_tdata,
  output net_stream_pkg::net_keep_t n_out_tkeep,
  output logic                      n_out_tlast,
  output logic                      n_out_tvalid,
  input  logic                      n_out_tready,
  // Stack side input, nclk
  input  net_stream_pkg::net_data_t n_in_tdata,
  input  net_stream_pkg::net_keep_t n_in_tkeep,
  input  logic                      n_in_tlast,
  input  logic                      n_in_tvalid,
  output logic                      n_in_tready,
  // Line side output, rclk
  output net_stream_pkg::net_data_t r_out_tdata,
  output net_stream_pkg::net_keep_t r_out_tkeep,
  output logic                      r_out_tlast,
  output logic                      r_out_tvalid,
  input  logic                      r_out_tready
);

  net_stream_if r_in ();
  net_stream_if n_out ();
  net_stream_if n_in ();
  net_stream_if r_out ();

  // Input groups drive the interface payload and read back ready
  assign r_in.tdata   = r_in_tdata;
  assign r_in.tkeep   = r_in_tkeep;
  assign r_in.tlast   = r_in_tlast;
  assign r_in.tvalid  = r_in_tvalid;
  assign r_in_tready  = r_in.tready;

  assign n_in.tdata   = n_in_tdata;
  assign n_in.tkeep   = n_in_tkeep;
  assign n_in.tlast   = n_in_tlast;
  assign n_in.tvalid  = n_in_tvalid;
  assign n_in_tready  = n_in.tready;

  // Output groups take the payload and feed ready in
  assign n_out_tdata  = n_out.tdata;
  assign n_out_tkeep  = n_out.tkeep;
  assign n_out_tlast  = n_out.tlast;
  assign n_out_tvalid = n_out.tvalid;
  assign n_out.tready = n_out_tready;

  assign r_out_tdata  = r_out.tdata;
  assign r_out_tkeep  = r_out.tkeep;
  assign r_out_tlast  = r_out.tlast;
  assign r_out_tvalid = r_out.tvalid;
  assign r_out.tready = r_out_tready;

  net_ccross_early #(
    .N_STGS    (N_STGS),
    .FIFO_AW   (FIFO_AW),
    .SYNC_STGS (SYNC_STGS)
  ) u_ccross (
    .rclk   (rclk),
    .nclk   (nclk),
    .reset  (reset),
    .s_rclk (r_in),
    .s_nclk (n_in),
    .m_rclk (r_out),
    .m_nclk (n_out)
  );

endmodule

/* dv/tb_net_cdc.sv */
// Testbench for the network clock crossing, run from the project root.
// Beats come from dv/net_cdc_input.mem and serve as stimulus and expected output.
// rclk and nclk are unrelated; both outputs see random back-pressure from an LFSR.
// The DUT runs with the default sizing from cdc_cfg_pkg.
`timescale 1ns/1ns

module tb_net_cdc;
  import net_stream_pkg::*;

  localparam int unsigned N_STGS     = cdc_cfg_pkg::DEF_N_STGS;
  localparam int unsigned FIFO_AW    = cdc_cfg_pkg::DEF_FIFO_AW;
  localparam int unsigned SYNC_STGS  = cdc_cfg_pkg::DEF_SYNC_STGS;
  // Beats one path can hold in two arrays of 2*N_STGS and the FIFO
  localparam int unsigned FILL_CAP   = 4 * N_STGS + 2 ** FIFO_AW;
  localparam int unsigned FILL_EXTRA = 4;
  localparam int unsigned MAX_BEATS  = 64;

  logic      rclk = 1'b0;
  logic      nclk = 1'b0;
  logic      reset = 1'b1;
  net_data_t r_in_tdata = '0;
  net_keep_t r_in_tkeep = '0;
  logic      r_in_tlast = 1'b0;
  logic      r_in_tvalid = 1'b0;
  logic      r_in_tready;
  net_data_t n_out_tdata;
  net_keep_t n_out_tkeep;
  logic      n_out_tlast;
  logic      n_out_tvalid;
  logic      n_out_tready = 1'b0;
  net_data_t n_in_tdata = '0;
  net_keep_t n_in_tkeep = '0;
  logic      n_in_tlast = 1'b0;
  logic      n_in_tvalid = 1'b0;
  logic      n_in_tready;
  net_data_t r_out_tdata;
  net_keep_t r_out_tkeep;
  logic      r_out_tlast;
  logic      r_out_tvalid;
  logic      r_out_tready = 1'b0;

  // File words hold direction, data, keep and last
  // Index 0 holds the r to n beats and index 1 the n to r beats
  logic [79:0] mem_words [MAX_BEATS];
  net_data_t   exp_data [2][MAX_BEATS];
  net_keep_t   exp_keep [2][MAX_BEATS];
  logic        exp_last [2][MAX_BEATS];
  int unsigned beat_cnt [2];
  bit          loaded;
  int unsigned wd_limit;

  int unsigned r_goal, r_sent, n_goal, n_sent;
  int unsigned r2n_rcvd, n2r_rcvd;
  int unsigned err [1:5];
  int unsigned n_checks, n_stalls, n_pass, n_fail;
  bit          hold_r_out, phase_c, r_take, n_take;
  // Each clock domain steps its own copy of the LFSR
  logic [31:0] r_lfsr = 32'hfb71_9831;
  logic [31:0] n_lfsr = 32'hfb71_9831;
  bit          n_stall, r_stall;
  net_data_t   n_held_d, r_held_d;
  net_keep_t   n_held_k, r_held_k;
  logic        n_held_l, r_held_l;

  net_cdc_top #(
    .N_STGS    (N_STGS),
    .FIFO_AW   (FIFO_AW),
    .SYNC_STGS (SYNC_STGS)
  ) u_dut (.*);

  always #5 nclk = ~nclk;
  always #3 rclk = ~rclk;

  // Galois form of x^32 + x^22 + x^2 + x + 1 that hands out state[0] as its bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  task automatic compare_payload(input string port, input int t,
                                 input net_data_t got_d, input net_data_t exp_d,
                                 input net_keep_t got_k, input net_keep_t exp_k,
                                 input logic got_l, input logic exp_l);
    n_checks++;
    assert (got_d === exp_d) else begin
      $display("FAIL %s_tdata: got %h, expected %h", port, got_d, exp_d);
      err[t]++;
    end
    assert (got_k === exp_k) else begin
      $display("FAIL %s_tkeep: got %h, expected %h", port, got_k, exp_k);
      err[t]++;
    end
    assert (got_l === exp_l) else begin
      $display("FAIL %s_tlast: got %h, expected %h", port, got_l, exp_l);
      err[t]++;
    end
  endtask

  task automatic check_outputs_idle();
    n_checks++;
    assert (n_out_tvalid === 1'b0) else begin
      $display("FAIL n_out_tvalid: got %h, expected 0", n_out_tvalid);
      err[1]++;
    end
    assert (r_out_tvalid === 1'b0) else begin
      $display("FAIL r_out_tvalid: got %h, expected 0", r_out_tvalid);
      err[1]++;
    end
    assert (n_in_tready === 1'b0) else begin
      $display("FAIL n_in_tready: got %h, expected 0", n_in_tready);
      err[1]++;
    end
    assert (r_in_tready === 1'b0) else begin
      $display("FAIL r_in_tready: got %h, expected 0", r_in_tready);
      err[1]++;
    end
  endtask

  task automatic report_test(input int t, input string name);
    if (err[t] == 0) begin
      $display("test %0d %s: passed", t, name);
      n_pass++;
    end else begin
      $display("test %0d %s: failed with %0d errors", t, name, err[t]);
      n_fail++;
    end
  endtask

  // The r_in driver idles on a one bit and also sets the r_out back-pressure
  always @(posedge rclk) begin
    if (r_in_tvalid && r_in_tready) begin
      r_sent++;
    end
    if (!r_in_tvalid || r_in_tready) begin
      r_take = 1'b0;
      if (r_sent < r_goal) begin
        r_take = !r_lfsr[0];
        r_lfsr = lfsr_next(r_lfsr);
      end
      if (r_take) begin
        r_in_tdata <= exp_data[0][r_sent % beat_cnt[0]];
        r_in_tkeep <= exp_keep[0][r_sent % beat_cnt[0]];
        r_in_tlast <= exp_last[0][r_sent % beat_cnt[0]];
      end
      r_in_tvalid <= r_take;
    end
    r_out_tready <= !hold_r_out && r_lfsr[0];
    r_lfsr = lfsr_next(r_lfsr);
  end

  // The n_in driver sends back to back during the fill test and sets the n_out back-pressure
  always @(posedge nclk) begin
    if (n_in_tvalid && n_in_tready) begin
      n_sent++;
    end
    if (!n_in_tvalid || n_in_tready) begin
      n_take = 1'b0;
      if (n_sent < n_goal && phase_c) begin
        n_take = 1'b1;
      end else if (n_sent < n_goal) begin
        n_take = !n_lfsr[0];
        n_lfsr = lfsr_next(n_lfsr);
      end
      if (n_take) begin
        n_in_tdata <= exp_data[1][n_sent % beat_cnt[1]];
        n_in_tkeep <= exp_keep[1][n_sent % beat_cnt[1]];
        n_in_tlast <= exp_last[1][n_sent % beat_cnt[1]];
      end
      n_in_tvalid <= n_take;
    end
    n_out_tready <= n_lfsr[0];
    n_lfsr = lfsr_next(n_lfsr);
  end

  // A beat stalled at the last n_out edge must still be there unchanged
  always @(posedge nclk) begin
    if (n_stall) begin
      n_stalls++;
      assert (n_out_tvalid === 1'b1) else begin
        $display("n_out_tvalid fell before the stalled beat was taken");
        err[4]++;
      end
      compare_payload("n_out", 4, n_out_tdata, n_held_d, n_out_tkeep, n_held_k,
                      n_out_tlast, n_held_l);
    end
    if (n_out_tvalid && n_out_tready) begin
      assert (r2n_rcvd < r_goal) else begin
        $display("n_out delivered more beats than the %0d that were sent", r_goal);
        err[2]++;
      end
      compare_payload("n_out", 2, n_out_tdata, exp_data[0][r2n_rcvd % beat_cnt[0]],
                      n_out_tkeep, exp_keep[0][r2n_rcvd % beat_cnt[0]],
                      n_out_tlast, exp_last[0][r2n_rcvd % beat_cnt[0]]);
      r2n_rcvd++;
    end
    n_stall  = n_out_tvalid && !n_out_tready;
    n_held_d = n_out_tdata;
    n_held_k = n_out_tkeep;
    n_held_l = n_out_tlast;
  end

  // The r_out monitor also serves the fill test once phase_c is set
  always @(posedge rclk) begin
    if (r_stall) begin
      n_stalls++;
      assert (r_out_tvalid === 1'b1) else begin
        $display("r_out_tvalid fell before the stalled beat was taken");
        err[phase_c ? 5 : 4]++;
      end
      compare_payload("r_out", phase_c ? 5 : 4, r_out_tdata, r_held_d, r_out_tkeep,
                      r_held_k, r_out_tlast, r_held_l);
    end
    if (r_out_tvalid && r_out_tready) begin
      assert (n2r_rcvd < n_goal) else begin
        $display("r_out delivered more beats than the %0d that were sent", n_goal);
        err[phase_c ? 5 : 3]++;
      end
      compare_payload("r_out", phase_c ? 5 : 3, r_out_tdata,
                      exp_data[1][n2r_rcvd % beat_cnt[1]],
                      r_out_tkeep, exp_keep[1][n2r_rcvd % beat_cnt[1]],
                      r_out_tlast, exp_last[1][n2r_rcvd % beat_cnt[1]]);
      n2r_rcvd++;
    end
    r_stall  = r_out_tvalid && !r_out_tready;
    r_held_d = r_out_tdata;
    r_held_k = r_out_tkeep;
    r_held_l = r_out_tlast;
  end

  // Budget of 40 nclk cycles per beat driven plus a start-up margin
  initial begin : watchdog
    wait (loaded);
    repeat (wd_limit) @(posedge nclk);
    $display("Timeout, the traffic did not complete within %0d nclk cycles", wd_limit);
    $display("Something failed");
    $finish;
  end

  initial begin : main_seq
    int unsigned d;
    int unsigned base;
    int unsigned accepted;
    int unsigned low_run;
    int unsigned total_err;
    $readmemh("dv/net_cdc_input.mem", mem_words);
    for (int i = 0; i < MAX_BEATS; i++) begin
      if (^mem_words[i] !== 1'bx) begin
        d = mem_words[i][76];
        exp_data[d][beat_cnt[d]] = mem_words[i][75:12];
        exp_keep[d][beat_cnt[d]] = mem_words[i][11:4];
        exp_last[d][beat_cnt[d]] = mem_words[i][0];
        beat_cnt[d]++;
      end
    end
    wd_limit = (beat_cnt[0] + beat_cnt[1] + FILL_CAP + FILL_EXTRA) * 40 + 500;
    loaded   = 1'b1;

    // Reset spans 8 rising nclk edges; the rclk copy needs a few cycles to arrive first
    for (int i = 0; i < 7; i++) begin
      @(negedge nclk);
      if (i >= 3) begin
        check_outputs_idle();
      end
    end
    @(posedge nclk);
    reset <= 1'b0;
    @(negedge nclk);
    check_outputs_idle();
    report_test(1, "outputs idle in reset");

    // Both directions at once under random idles and back-pressure
    assert (beat_cnt[0] > 0 && beat_cnt[1] > 0) else begin
      $display("The stimulus file holds no beats for one of the directions");
      err[2]++;
    end
    r_goal = beat_cnt[0];
    n_goal = beat_cnt[1];
    wait (r2n_rcvd == r_goal && n2r_rcvd == n_goal);
    @(negedge nclk);
    report_test(2, "r to n order and payload");
    report_test(3, "n to r order and payload");
    assert (n_stalls > 0) else begin
      $display("Back-pressure never stalled an output beat");
      err[4]++;
    end
    report_test(4, "payload held under back-pressure");

    // Hold r_out and keep offering beats until n_in stays blocked
    phase_c    = 1'b1;
    hold_r_out = 1'b1;
    repeat (4) @(negedge nclk);
    base    = n_sent;
    n_goal  = base + FILL_CAP + FILL_EXTRA;
    low_run = 0;
    while (low_run < 32 && n_sent < n_goal) begin
      @(negedge nclk);
      if (n_in_tready) begin
        low_run = 0;
      end else begin
        low_run++;
      end
    end
    accepted = n_sent - base;
    $display("n_in took %0d beats with r_out held", accepted);
    assert (low_run == 32) else begin
      $display("n_in_tready never stayed low while r_out was held");
      err[5]++;
    end
    assert (accepted <= FILL_CAP) else begin
      $display("n_in took %0d beats but the path only holds %0d", accepted, FILL_CAP);
      err[5]++;
    end
    hold_r_out = 1'b0;
    wait (n_sent == n_goal && n2r_rcvd == n_goal);
    @(negedge nclk);
    report_test(5, "fill and drain with r_out held");

    total_err = 0;
    for (int t = 1; t <= 5; t++) begin
      total_err += err[t];
    end
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, n_checks, total_err);
    if (total_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dv/net_cdc_input.mem */
// Columns: direction, tdata, tkeep, tlast in hex, split by underscores
// Direction 0 enters at r_in and leaves at n_out, 1 enters at n_in and leaves at r_out
0_0011223344556677_ff_0
1_a5a5a5a500000001_ff_0
0_8899aabbccddeeff_ff_0
1_a5a5a5a500000002_ff_0
0_0123456789abcdef_0f_1
1_a5a5a5a500000003_ff_0
0_00000000000000c3_03_1
1_0000a5a5a5a5a504_3f_1
0_fedcba9876543210_ff_0
1_c001d00de0000001_ff_0
0_1111111111111111_ff_0
1_00000000000000e2_01_1
0_2222222222222222_ff_0
1_8000000000000000_ff_0
0_3333333333333333_ff_0
1_4000000000000000_ff_0
0_4444444444444444_ff_1
1_2000000000000000_ff_0
0_deadbeefcafef00d_ff_0
1_1000000000000000_ff_0
0_0f0f0f0f0f0f0f0f_ff_0
1_0800000000000000_ff_0
0_f0f0f0f0f0f0f0f0_ff_0
1_0400000000000000_ff_1
0_5555aaaa5555aaaa_ff_0
1_6b6b6b6b6b6b6b6b_ff_0
0_007766554433221a_7f_1
1_000000006b6b6b6b_0f_1

/* project.f */
rtl/net_stream_pkg.sv
rtl/cdc_cfg_pkg.sv
rtl/net_stream_if.sv
rtl/axis_reg_array.sv
rtl/async_stream_fifo.sv
rtl/net_ccross_early.sv
rtl/net_cdc_top.sv
dv/tb_net_cdc.sv

/* Bender.yml */
package:
  name: net_cdc

sources:
  # Packages first, then the interface and the design from the leaves up
  - rtl/net_stream_pkg.sv
  - rtl/cdc_cfg_pkg.sv
  - rtl/net_stream_if.sv
  - rtl/axis_reg_array.sv
  - rtl/async_stream_fifo.sv
  - rtl/net_ccross_early.sv
  - rtl/net_cdc_top.sv

  - target: simulation
    files:
      - dv/tb_net_cdc.sv
